// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     = --timing --assert
SIM_FLAGS = -Wno-fatal
TB_TOP    = tb_fractal_top
RTL_TOP   = fractal_top
FILELIST  = src.f
OBJ_DIR   = obj_dir
PASS_MSG  = all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# Pass only if the exact pass line shows up in the simulation output
sim:
	$(VERILATOR) --binary $(FLAGS) $(SIM_FLAGS) -f $(FILELIST) \
		--top-module $(TB_TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== src.f ====
+incdir+verilog
verilog/fractal_pkg.sv
verilog/pixel_job_if.sv
verilog/pixel_counter.sv
verilog/dispatcher.sv
verilog/escape_worker.sv
verilog/result_collector.sv
verilog/fractal_top.sv
tb/tb_fractal_top.sv

// ==== tb/tb_fractal_top.sv ====
`default_nettype none

`include "fractal_consts.svh"

module tb_fractal_top;

	localparam int img_w = `FRACTAL_IMG_W;
	localparam int img_h = `FRACTAL_IMG_H;
	localparam int n_pix = img_w * img_h;
	localparam int n_frames = 3;
	localparam int frame_timeout = 20000;

	logic clk;
	logic n_reset;
	logic go;
	logic pixel_valid;
	fractal_pkg::x_t pixel_x;
	fractal_pkg::y_t pixel_y;
	fractal_pkg::iter_t pixel_iter;
	logic busy;
	logic frame_done;

	logic [31:0] lfsr;
	int errors;
	int cur_frame;
	logic timed_out;
	int exp_iter [n_pix];

	// Owned by the output monitor
	int mon_errors = 0;
	int seen [n_pix];
	int frame_res [n_frames][n_pix];
	int pix_count = 0;
	int done_pulses = 0;
	logic go_issued = 1'b0;
	logic hit_limit = 1'b0;

	fractal_top uut (
		.clk(clk),
		.n_reset(n_reset),
		.go(go),
		.pixel_valid(pixel_valid),
		.pixel_x(pixel_x),
		.pixel_y(pixel_y),
		.pixel_iter(pixel_iter),
		.busy(busy),
		.frame_done(frame_done)
	);

	always #5 clk = ~clk;

	// 32-bit Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output int val);
		val = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			val = (val << 1) | int'(lfsr[0]);
		end
	endtask

	// Keep the low 16 bits as a signed Q4.12 value
	function automatic int wrap16(input int v);
		logic signed [15:0] t;
		t = v[15:0];
		return int'(t);
	endfunction

	// Q4.12 product floored and clamped to the 16-bit range
	function automatic int q_mul(input int a, input int b);
		int p;
		p = (a * b) >>> `FRACTAL_FRAC_BITS;
		if (p > 32767) begin
			p = 32767;
		end else if (p < -32768) begin
			p = -32768;
		end
		return p;
	endfunction

	// Escape-time count for one pixel
	function automatic int ref_iter(input int x, input int y);
		int c_re;
		int c_im;
		int z_re;
		int z_im;
		int zr2;
		int zi2;
		int zri;
		int n;
		logic esc;
		c_re = wrap16(wrap16(`FRACTAL_RE_ORIGIN) + x * wrap16(`FRACTAL_STEP));
		c_im = wrap16(wrap16(`FRACTAL_IM_ORIGIN) + y * wrap16(`FRACTAL_STEP));
		z_re = 0;
		z_im = 0;
		n = 0;
		esc = 1'b0;
		while (!esc && n < `FRACTAL_MAX_ITER) begin
			zr2 = q_mul(z_re, z_re);
			zi2 = q_mul(z_im, z_im);
			zri = q_mul(z_re, z_im);
			// Test on the current z against 4.0 in Q4.12
			if (zr2 + zi2 > (4 << `FRACTAL_FRAC_BITS)) begin
				esc = 1'b1;
			end else begin
				z_re = wrap16(zr2 - zi2 + c_re);
				z_im = wrap16(2 * zri + c_im);
				n++;
			end
		end
		return n;
	endfunction

	task automatic check_quiet(input string phase);
		assert (!pixel_valid && !frame_done && !busy) else begin
			errors++;
			$display("[FAIL] %s: pixel_valid=%h frame_done=%h busy=%h, expected 0",
				phase, pixel_valid, frame_done, busy);
		end
	endtask

	// Output monitor and scoreboard
	always @(posedge clk) begin : monitor
		int idx;
		if (!n_reset) begin
			if (go) begin
				go_issued <= 1'b1;
				pix_count = 0;
				done_pulses = 0;
				for (int i = 0; i < n_pix; i++) begin
					seen[i] = 0;
				end
			end
			if (pixel_valid) begin
				assert (go_issued && done_pulses == 0) else begin
					mon_errors++;
					$display("pixel_valid seen outside a running frame");
				end
				assert (busy) else begin
					mon_errors++;
					$display("[FAIL] busy=%h with pixel_valid, expected 1", busy);
				end
				assert (int'(pixel_x) < img_w && int'(pixel_y) < img_h) else begin
					mon_errors++;
					$display("[FAIL] pixel_x=%h pixel_y=%h outside image", pixel_x, pixel_y);
				end
				if (int'(pixel_x) < img_w && int'(pixel_y) < img_h) begin
					idx = int'(pixel_y) * img_w + int'(pixel_x);
					assert (int'(pixel_iter) == exp_iter[idx]) else begin
						mon_errors++;
						$display("[FAIL] pixel_iter at (%h,%h) got %h expected %h",
							pixel_x, pixel_y, pixel_iter, exp_iter[idx]);
					end
					assert (seen[idx] == 0) else begin
						mon_errors++;
						$display("Pixel (%0d,%0d) delivered twice", pixel_x, pixel_y);
					end
					seen[idx]++;
					frame_res[cur_frame][idx] = int'(pixel_iter);
					if (int'(pixel_iter) == `FRACTAL_MAX_ITER) begin
						hit_limit <= 1'b1;
					end
					pix_count++;
				end
			end
			if (frame_done) begin
				assert (pix_count == n_pix) else begin
					mon_errors++;
					$display("[FAIL] pixel count at frame_done got %h expected %h",
						pix_count, n_pix);
				end
				assert (done_pulses == 0) else begin
					mon_errors++;
					$display("frame_done pulsed more than once in a frame");
				end
				assert (!busy) else begin
					mon_errors++;
					$display("[FAIL] busy=%h at frame_done, expected 0", busy);
				end
				done_pulses++;
			end
		end
	end

	task automatic run_frame(input int f);
		int gap;
		int cycles;
		take_bits(4, gap);
		repeat (gap) @(negedge clk);
		cur_frame = f;
		go = 1'b1;
		@(negedge clk);
		go = 1'b0;
		cycles = 0;
		while (done_pulses == 0 && cycles < frame_timeout) begin
			@(negedge clk);
			cycles++;
		end
		if (done_pulses == 0) begin
			errors++;
			timed_out = 1'b1;
			$display("Timeout: no frame_done within %0d cycles in frame %0d",
				frame_timeout, f);
		end else begin
			// Quiet tail where a stray pixel is caught by the monitor
			repeat (4) @(negedge clk);
			assert (!busy) else begin
				errors++;
				$display("[FAIL] busy=%h after frame %0d, expected 0", busy, f);
			end
			for (int i = 0; i < n_pix; i++) begin
				assert (seen[i] == 1) else begin
					errors++;
					$display("Pixel (%0d,%0d) appeared %0d times in frame %0d",
						i % img_w, i / img_w, seen[i], f);
				end
				if (f > 0) begin
					assert (frame_res[f][i] == frame_res[0][i]) else begin
						errors++;
						$display("[FAIL] frame %0d pixel_iter at %h got %h, frame 0 had %h",
							f, i, frame_res[f][i], frame_res[0][i]);
					end
				end
			end
		end
	endtask

	initial begin
		clk = 1'b0;
		n_reset = 1'b1;
		go = 1'b0;
		lfsr = 32'hbc08;
		errors = 0;
		cur_frame = 0;
		timed_out = 1'b0;
		for (int i = 0; i < n_pix; i++) begin
			exp_iter[i] = ref_iter(i % img_w, i / img_w);
		end

		repeat (5) begin
			@(negedge clk);
			check_quiet("in reset");
		end
		n_reset = 1'b0;
		repeat (3) begin
			@(negedge clk);
			check_quiet("before go");
		end

		// Back-to-back frames with random idle gaps
		for (int f = 0; f < n_frames; f++) begin
			if (!timed_out) begin
				run_frame(f);
			end
		end

		assert (hit_limit) else begin
			errors++;
			$display("No pixel reached the iteration limit");
		end

		$display("Checks finished with %0d errors", errors + mon_errors);
		if (errors + mon_errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/dispatcher.sv ====
`default_nettype none

`include "fractal_consts.svh"

module dispatcher (
	input wire clk,
	input wire n_reset,
	input wire go,
	input wire last_issued,
	input wire fractal_pkg::worker_mask_t done,
	pixel_job_if.dispatch job,
	output logic busy,
	output logic frame_done
);

	fractal_pkg::dispatch_state_t state;
	fractal_pkg::dispatch_state_t nxt_state;
	fractal_pkg::worker_id_t lowest_idle;
	fractal_pkg::worker_id_t select_q;
	logic frame_done_q;

	// Priority encoder, lowest index wins
	always_comb begin
		lowest_idle = '0;
		for (int i = `FRACTAL_WORKERS - 1; i >= 0; i--) begin
			if (done[i]) begin
				lowest_idle = fractal_pkg::worker_id_t'(i);
			end
		end
	end

	always_comb begin
		nxt_state = state;
		case (state)
			fractal_pkg::idle: begin
				if (go) begin
					nxt_state = fractal_pkg::find;
				end
			end
			fractal_pkg::find: begin
				if (last_issued) begin
					nxt_state = fractal_pkg::finished;
				end else if (|done) begin
					nxt_state = fractal_pkg::dispatch;
				end
			end
			fractal_pkg::dispatch: begin
				nxt_state = fractal_pkg::jw_start;
			end
			fractal_pkg::jw_start: begin
				nxt_state = fractal_pkg::find;
			end
			fractal_pkg::finished: begin
				// Drain until every worker is back to idle
				if (&done) begin
					nxt_state = fractal_pkg::idle;
				end
			end
			default: begin
				nxt_state = fractal_pkg::idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (n_reset) begin
			state <= fractal_pkg::idle;
			select_q <= '0;
			frame_done_q <= 1'b0;
		end else begin
			state <= nxt_state;
			frame_done_q <= (state == fractal_pkg::finished) && (&done);
			if (state == fractal_pkg::dispatch) begin
				select_q <= lowest_idle;
			end
		end
	end

	assign job.start = (state == fractal_pkg::jw_start);
	assign job.select_worker = select_q;
	assign busy = (state != fractal_pkg::idle);
	assign frame_done = frame_done_q;

	// A job only ever goes to a worker that reports idle
	a_start_to_idle: assert property (
		@(posedge clk) disable iff (n_reset)
		job.start |-> done[job.select_worker]
	);

	a_frame_done_pulse: assert property (
		@(posedge clk) disable iff (n_reset)
		frame_done |=> !frame_done
	);

endmodule

`default_nettype wire

// ==== verilog/escape_worker.sv ====
`default_nettype none

`include "fractal_consts.svh"

module escape_worker (
	input wire clk,
	input wire n_reset,
	input wire fractal_pkg::worker_id_t id,
	pixel_job_if.worker job,
	input wire ack,
	output logic done,
	output logic ready,
	output fractal_pkg::x_t res_x,
	output fractal_pkg::y_t res_y,
	output fractal_pkg::iter_t res_iter
);

	typedef enum logic [1:0] {
		w_idle,
		w_load,
		w_run,
		w_hold
	} worker_state_t;

	localparam int fix_max = (2 ** (`FRACTAL_FIX_W - 1)) - 1;
	localparam int fix_min = -(2 ** (`FRACTAL_FIX_W - 1));
	// |z|^2 limit of 4.0 in a value one bit wider than Q4.12
	localparam logic signed [`FRACTAL_FIX_W:0] escape_lim =
		(`FRACTAL_FIX_W + 1)'(4 << `FRACTAL_FRAC_BITS);

	worker_state_t state;
	logic picked;
	logic finish;
	logic escaped;
	fractal_pkg::fix_t c_re;
	fractal_pkg::fix_t c_im;
	fractal_pkg::fix_t z_re;
	fractal_pkg::fix_t z_im;
	fractal_pkg::fix_t zr2;
	fractal_pkg::fix_t zi2;
	fractal_pkg::fix_t zri;
	logic signed [`FRACTAL_FIX_W:0] mag;

	// Q4.12 multiply saturated to the 16-bit range
	function automatic fractal_pkg::fix_t fix_mul(
		input fractal_pkg::fix_t a,
		input fractal_pkg::fix_t b
	);
		logic signed [2*`FRACTAL_FIX_W-1:0] prod;
		prod = a * b;
		prod = prod >>> `FRACTAL_FRAC_BITS;
		if (prod > fix_max) begin
			return fractal_pkg::fix_t'(fix_max);
		end else if (prod < fix_min) begin
			return fractal_pkg::fix_t'(fix_min);
		end
		return prod[`FRACTAL_FIX_W-1:0];
	endfunction

	assign picked = job.start && (job.select_worker == id);

	assign zr2 = fix_mul(z_re, z_re);
	assign zi2 = fix_mul(z_im, z_im);
	assign zri = fix_mul(z_re, z_im);
	assign mag = {zr2[`FRACTAL_FIX_W-1], zr2} + {zi2[`FRACTAL_FIX_W-1], zi2};
	// Escape is judged on the current z before any update
	assign escaped = (mag > escape_lim);
	assign finish = escaped || (res_iter == fractal_pkg::iter_t'(`FRACTAL_MAX_ITER));

	always_ff @(posedge clk) begin
		if (n_reset) begin
			state <= w_idle;
		end else begin
			case (state)
				w_idle: begin
					if (picked) begin
						state <= w_load;
					end
				end
				w_load: begin
					state <= w_run;
				end
				w_run: begin
					if (finish) begin
						state <= w_hold;
					end
				end
				w_hold: begin
					if (ack) begin
						state <= w_idle;
					end
				end
				default: begin
					state <= w_idle;
				end
			endcase
		end
	end

	// Datapath steered by the FSM
	always_ff @(posedge clk) begin
		if (state == w_idle && picked) begin
			res_x <= job.x;
			res_y <= job.y;
		end
		if (state == w_load) begin
			// c = origin + coordinate * step
			c_re <= fractal_pkg::fix_t'(`FRACTAL_RE_ORIGIN)
				+ fractal_pkg::fix_t'(res_x) * fractal_pkg::fix_t'(`FRACTAL_STEP);
			c_im <= fractal_pkg::fix_t'(`FRACTAL_IM_ORIGIN)
				+ fractal_pkg::fix_t'(res_y) * fractal_pkg::fix_t'(`FRACTAL_STEP);
			z_re <= '0;
			z_im <= '0;
			res_iter <= '0;
		end
		if (state == w_run && !finish) begin
			z_re <= zr2 - zi2 + c_re;
			z_im <= zri + zri + c_im;
			res_iter <= res_iter + fractal_pkg::iter_t'(1);
		end
	end

	assign done = (state == w_idle);
	assign ready = (state == w_hold);

	// Count stops at the limit instead of wrapping
	a_iter_limit: assert property (
		@(posedge clk) disable iff (n_reset)
		(state == w_run && res_iter == fractal_pkg::iter_t'(`FRACTAL_MAX_ITER))
			|=> (ready && res_iter == fractal_pkg::iter_t'(`FRACTAL_MAX_ITER))
	);

endmodule

`default_nettype wire

// ==== verilog/fractal_consts.svh ====
`ifndef FRACTAL_CONSTS_SVH
`define FRACTAL_CONSTS_SVH

// Image size in pixels
`define FRACTAL_IMG_W 16
`define FRACTAL_IMG_H 12

// Pixel coordinate widths
`define FRACTAL_X_BITS 4
`define FRACTAL_Y_BITS 4

// Worker pool
`define FRACTAL_WORKERS 16
`define FRACTAL_WID_BITS 4

// Signed Q4.12 fixed point
`define FRACTAL_FIX_W 16
`define FRACTAL_FRAC_BITS 12

// Iteration limit and counter width
`define FRACTAL_MAX_ITER 31
`define FRACTAL_ITER_BITS 5

// Plane origin (-2.0, -1.125) and 0.1875 per pixel, all Q4.12
`define FRACTAL_RE_ORIGIN 16'hE000
`define FRACTAL_IM_ORIGIN 16'hEE00
`define FRACTAL_STEP 16'h0300

`endif

// ==== verilog/fractal_pkg.sv ====
`default_nettype none

`include "fractal_consts.svh"

package fractal_pkg;

	// Pixel coordinates
	typedef logic [`FRACTAL_X_BITS-1:0] x_t;
	typedef logic [`FRACTAL_Y_BITS-1:0] y_t;

	// Worker index and one bit per worker
	typedef logic [`FRACTAL_WID_BITS-1:0] worker_id_t;
	typedef logic [`FRACTAL_WORKERS-1:0] worker_mask_t;

	// Q4.12 value
	typedef logic signed [`FRACTAL_FIX_W-1:0] fix_t;

	typedef logic [`FRACTAL_ITER_BITS-1:0] iter_t;

	// Frame-level dispatch FSM
	typedef enum logic [2:0] {
		idle,
		find,
		dispatch,
		jw_start,
		finished
	} dispatch_state_t;

endpackage

`default_nettype wire

// ==== verilog/fractal_top.sv ====
`default_nettype none

`include "fractal_consts.svh"

module fractal_top (
	input wire clk,
	input wire n_reset,
	input wire go,
	output logic pixel_valid,
	output fractal_pkg::x_t pixel_x,
	output fractal_pkg::y_t pixel_y,
	output fractal_pkg::iter_t pixel_iter,
	output logic busy,
	output logic frame_done
);

	pixel_job_if job ();

	logic last_issued;
	fractal_pkg::worker_mask_t done;
	fractal_pkg::worker_mask_t ready;
	fractal_pkg::worker_mask_t ack;
	fractal_pkg::x_t res_x [`FRACTAL_WORKERS];
	fractal_pkg::y_t res_y [`FRACTAL_WORKERS];
	fractal_pkg::iter_t res_iter [`FRACTAL_WORKERS];

	pixel_counter u_counter (
		.clk(clk),
		.n_reset(n_reset),
		.go(go),
		.job(job.source),
		.last_issued(last_issued)
	);

	dispatcher u_dispatcher (
		.clk(clk),
		.n_reset(n_reset),
		.go(go),
		.last_issued(last_issued),
		.done(done),
		.job(job.dispatch),
		.busy(busy),
		.frame_done(frame_done)
	);

	// Worker pool
	for (genvar i = 0; i < `FRACTAL_WORKERS; i++) begin : g_worker
		escape_worker u_worker (
			.clk(clk),
			.n_reset(n_reset),
			.id(fractal_pkg::worker_id_t'(i)),
			.job(job.worker),
			.ack(ack[i]),
			.done(done[i]),
			.ready(ready[i]),
			.res_x(res_x[i]),
			.res_y(res_y[i]),
			.res_iter(res_iter[i])
		);
	end

	result_collector u_collector (
		.clk(clk),
		.n_reset(n_reset),
		.ready(ready),
		.res_x(res_x),
		.res_y(res_y),
		.res_iter(res_iter),
		.ack(ack),
		.pixel_valid(pixel_valid),
		.pixel_x(pixel_x),
		.pixel_y(pixel_y),
		.pixel_iter(pixel_iter)
	);

endmodule

`default_nettype wire

// ==== verilog/pixel_counter.sv ====
`default_nettype none

`include "fractal_consts.svh"

module pixel_counter (
	input wire clk,
	input wire n_reset,
	input wire go,
	pixel_job_if.source job,
	output logic last_issued
);

	logic row_end;
	logic col_end;

	assign row_end = (job.x == fractal_pkg::x_t'(`FRACTAL_IMG_W - 1));
	assign col_end = (job.y == fractal_pkg::y_t'(`FRACTAL_IMG_H - 1));

	// Raster walk, one step per issued job
	always_ff @(posedge clk) begin
		if (n_reset) begin
			job.x <= '0;
			job.y <= '0;
			last_issued <= 1'b0;
		end else if (go) begin
			job.x <= '0;
			job.y <= '0;
			last_issued <= 1'b0;
		end else if (job.start) begin
			if (row_end) begin
				job.x <= '0;
				if (col_end) begin
					// Final pixel gone, hold until the next frame
					last_issued <= 1'b1;
				end else begin
					job.y <= job.y + fractal_pkg::y_t'(1);
				end
			end else begin
				job.x <= job.x + fractal_pkg::x_t'(1);
			end
		end
	end

	// Dispatcher must stop handing out jobs once the frame is exhausted
	a_no_start_after_last: assert property (
		@(posedge clk) disable iff (n_reset)
		job.start |-> !last_issued
	);

endmodule

`default_nettype wire

// ==== verilog/pixel_job_if.sv ====
`default_nettype none

interface pixel_job_if;

	// Job strobe and target worker
	logic start;
	fractal_pkg::worker_id_t select_worker;

	// Coordinate of the pixel being handed out
	fractal_pkg::x_t x;
	fractal_pkg::y_t y;

	modport dispatch (
		output start,
		output select_worker
	);

	// Counter sees the strobe so it can step to the next pixel
	modport source (
		input start,
		output x,
		output y
	);

	modport worker (
		input start,
		input select_worker,
		input x,
		input y
	);

endinterface

`default_nettype wire

// ==== verilog/result_collector.sv ====
`default_nettype none

`include "fractal_consts.svh"

module result_collector (
	input wire clk,
	input wire n_reset,
	input wire fractal_pkg::worker_mask_t ready,
	input wire fractal_pkg::x_t res_x [`FRACTAL_WORKERS],
	input wire fractal_pkg::y_t res_y [`FRACTAL_WORKERS],
	input wire fractal_pkg::iter_t res_iter [`FRACTAL_WORKERS],
	output fractal_pkg::worker_mask_t ack,
	output logic pixel_valid,
	output fractal_pkg::x_t pixel_x,
	output fractal_pkg::y_t pixel_y,
	output fractal_pkg::iter_t pixel_iter
);

	fractal_pkg::worker_id_t ptr;
	fractal_pkg::worker_id_t idx;
	fractal_pkg::worker_id_t grant_id;
	logic found;

	// Round robin search that starts at ptr and wraps
	always_comb begin
		found = 1'b0;
		grant_id = '0;
		idx = '0;
		for (int k = 0; k < `FRACTAL_WORKERS; k++) begin
			idx = fractal_pkg::worker_id_t'(ptr + k);
			if (!found && ready[idx]) begin
				found = 1'b1;
				grant_id = idx;
			end
		end
	end

	// The granted worker is released on this same edge
	assign ack = found ? (fractal_pkg::worker_mask_t'(1) << grant_id) : '0;

	always_ff @(posedge clk) begin
		if (n_reset) begin
			pixel_valid <= 1'b0;
			ptr <= '0;
		end else begin
			pixel_valid <= found;
			if (found) begin
				ptr <= grant_id + fractal_pkg::worker_id_t'(1);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (found) begin
			pixel_x <= res_x[grant_id];
			pixel_y <= res_y[grant_id];
			pixel_iter <= res_iter[grant_id];
		end
	end

	// Only a worker holding a result is released
	a_ack_onehot: assert property (
		@(posedge clk) disable iff (n_reset)
		$onehot0(ack) && ((ack & ~ready) == '0)
	);

endmodule

`default_nettype wire
